// ==== uplink_pkg.sv ====
package uplink_pkg;

  //////////////////////
  // pixel format
  //////////////////////

  // rgb332, red in the top bits as the frame store holds it
  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
  } pixel_t;

  // byte order on the wire per pixel
  // green goes first, then blue, then red
  typedef enum logic [1:0] {
    PHASE_GREEN = 2'd0,
    PHASE_BLUE  = 2'd1,
    PHASE_RED   = 2'd2
  } color_phase_t;

  //////////////////////
  // control states
  //////////////////////

  // idle: frame open for writes
  // send: pixels being read and split
  // drain: last bytes still leaving the line
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SEND  = 2'd1,
    ST_DRAIN = 2'd2
  } uplink_state_t;

  //////////////////////
  // default sizes
  //////////////////////

  // 640 x 400 frame
  localparam int DEFAULT_NUM_PIXELS = 256000;

  // clocks per serial bit
  localparam int DEFAULT_CLKS_PER_BIT = 352;

  // 18 bits for the default frame
  localparam int ADDR_W = $clog2(DEFAULT_NUM_PIXELS);

endpackage

// ==== frame_store.sv ====
`timescale 1ns/1ps

module frame_store #(
  parameter int NUM_PIXELS = uplink_pkg::DEFAULT_NUM_PIXELS
) (
  input  logic                          clk,
  input  logic                          uart_reset,
  input  logic                          wr_en,
  input  logic [$clog2(NUM_PIXELS)-1:0] wr_addr,
  input  uplink_pkg::pixel_t            wr_data,
  input  logic                          rd_en,
  input  logic [$clog2(NUM_PIXELS)-1:0] rd_addr,
  output uplink_pkg::pixel_t            rd_data,
  output logic                          rd_data_valid
);
  import uplink_pkg::*;

  // one pixel per word, one frame deep
  pixel_t mem [NUM_PIXELS];

  // write port, load side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // valid tracks the read enable
  always_ff @(posedge clk) begin
    if (uart_reset) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_en;
    end
  end

endmodule

// ==== pixel_counter.sv ====
`timescale 1ns/1ps

module pixel_counter #(
  parameter int NUM_PIXELS = uplink_pkg::DEFAULT_NUM_PIXELS
) (
  input  logic                          clk,
  input  logic                          uart_reset,
  input  logic                          send_active,
  input  logic                          pix_req,
  output logic                          rd_en,
  output logic [$clog2(NUM_PIXELS)-1:0] rd_addr,
  output logic                          frame_done,
  output logic [uplink_pkg::ADDR_W:0]   pixels_sent
);
  import uplink_pkg::*;

  localparam int AW = $clog2(NUM_PIXELS);
  // one extra bit so the count can reach NUM_PIXELS
  localparam int CW = AW + 1;
  localparam logic [CW-1:0] FRAME_COUNT = CW'(NUM_PIXELS);

  logic [CW-1:0] count;
  logic          active_q;
  logic          running;
  logic          exhausted;

  //////////////////////
  // read issue
  //////////////////////

  // first send cycle only clears the count
  // stale count from the last frame must not issue or finish
  assign running   = send_active & active_q;
  assign exhausted = (count == FRAME_COUNT);

  // one read per request until the frame runs out
  assign rd_en   = running & pix_req & ~exhausted;
  assign rd_addr = count[AW-1:0];

  // high from the cycle after the last read
  assign frame_done = running & exhausted;

  // progress value, holds after the frame ends
  assign pixels_sent = (ADDR_W + 1)'(count);

  //////////////////////
  // counter
  //////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      active_q <= 1'b0;
      count    <= '0;
    end else begin
      active_q <= send_active;
      // rising edge of send starts a new frame
      if (send_active && !active_q) begin
        count <= '0;
      end else if (rd_en) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// ==== frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader (
  input  logic               clk,
  input  logic               uart_reset,
  input  uplink_pkg::pixel_t rd_data,
  input  logic               rd_data_valid,
  input  logic               byte_ready,
  output logic               pix_req,
  output logic               byte_valid,
  output logic [7:0]         byte_data,
  output logic               reader_empty
);
  import uplink_pkg::*;

  pixel_t       pix;
  color_phase_t phase;
  logic         full;
  logic         accept;
  logic         last_byte;

  //////////////////////
  // handshakes
  //////////////////////

  assign byte_valid = full;
  assign accept     = byte_valid & byte_ready;
  assign last_byte  = (phase == PHASE_RED);

  // ask for the next pixel when the holder is free
  // or its red byte goes out this cycle
  // a returning read counts as occupied
  assign pix_req = ~rd_data_valid & (~full | (last_byte & accept));

  // nothing held and nothing on the way
  assign reader_empty = ~full & ~rd_data_valid;

  //////////////////////
  // byte split
  //////////////////////

  // color field in the top bits, zeros below
  always_comb begin
    case (phase)
      PHASE_GREEN: byte_data = {pix.green, 5'b0};
      PHASE_BLUE:  byte_data = {pix.blue, 6'b0};
      PHASE_RED:   byte_data = {pix.red, 5'b0};
      default:     byte_data = 8'h00;
    endcase
  end

  //////////////////////
  // holder
  //////////////////////

  // pixel payload
  always_ff @(posedge clk) begin
    if (rd_data_valid) begin
      pix <= rd_data;
    end
  end

  // occupancy and phase
  always_ff @(posedge clk) begin
    if (uart_reset) begin
      full  <= 1'b0;
      phase <= PHASE_GREEN;
    end else if (rd_data_valid) begin
      // fresh pixel, start over at green
      full  <= 1'b1;
      phase <= PHASE_GREEN;
    end else if (accept) begin
      case (phase)
        PHASE_GREEN: phase <= PHASE_BLUE;
        PHASE_BLUE:  phase <= PHASE_RED;
        default: begin
          // red sent, holder free again
          phase <= PHASE_GREEN;
          full  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = uplink_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       uart_reset,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  output logic       tx_idle,
  output logic       txd
);

  // wide enough to hold CLKS_PER_BIT - 1
  localparam int TW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [TW-1:0] TIMER_LAST = TW'(CLKS_PER_BIT - 1);
  // start is bit 0, stop is bit 9
  localparam logic [3:0] STOP_IDX = 4'd9;

  logic          active;
  logic [TW-1:0] bit_timer;
  logic [3:0]    bit_idx;
  logic [9:0]    tx_shift;
  logic          bit_end;
  logic          accept;

  //////////////////////
  // byte handshake
  //////////////////////

  // takes a byte only between frames
  assign byte_ready = ~active;
  assign accept     = byte_valid & byte_ready;

  // idle again once the stop bit has run out
  assign tx_idle = ~active;

  //////////////////////
  // line
  //////////////////////

  // line level is the bottom of the shift register
  // ones shift in from the top so the line rests high
  assign txd = tx_shift[0];

  // last clock of the current bit
  assign bit_end = active & (bit_timer == TIMER_LAST);

  //////////////////////
  // bit timer, shifter
  //////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      active    <= 1'b0;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx_shift  <= '1;
    end else if (accept) begin
      // stop, data lsb first, start
      // start bit on the line next cycle
      active    <= 1'b1;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx_shift  <= {1'b1, byte_data, 1'b0};
    end else if (active) begin
      if (bit_end) begin
        bit_timer <= '0;
        tx_shift  <= {1'b1, tx_shift[9:1]};
        // done after the stop bit
        if (bit_idx == STOP_IDX) begin
          active <= 1'b0;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        bit_timer <= bit_timer + 1'b1;
      end
    end
  end

endmodule

// ==== uplink_fsm.sv ====
`timescale 1ns/1ps

module uplink_fsm (
  input  logic clk,
  input  logic uart_reset,
  input  logic send_start,
  input  logic frame_done,
  input  logic reader_empty,
  input  logic tx_idle,
  output logic send_active,
  output logic wr_allowed,
  output logic busy
);
  import uplink_pkg::*;

  uplink_state_t state;
  uplink_state_t state_next;

  //////////////////////
  // next state
  //////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        // start pulses outside idle are dropped
        if (send_start) begin
          state_next = ST_SEND;
        end
      end
      ST_SEND: begin
        // every address read
        if (frame_done) begin
          state_next = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // last pixel split and its red byte off the line
        if (reader_empty && tx_idle) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  //////////////////////
  // state register
  //////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////
  // outputs
  //////////////////////

  // reads run only in send
  assign send_active = (state == ST_SEND);

  // frame store takes writes only when nothing is going out
  assign wr_allowed = (state == ST_IDLE);

  // covers the serial tail through drain
  assign busy = (state != ST_IDLE);

endmodule

// ==== frame_uplink.sv ====
`timescale 1ns/1ps

module frame_uplink #(
  parameter int NUM_PIXELS   = uplink_pkg::DEFAULT_NUM_PIXELS,
  parameter int CLKS_PER_BIT = uplink_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                          clk,
  input  logic                          uart_reset,
  input  logic                          pix_wr_valid,
  input  logic [uplink_pkg::ADDR_W-1:0] pix_wr_addr,
  input  uplink_pkg::pixel_t            pix_wr_data,
  input  logic                          send_start,
  output logic                          pix_wr_ready,
  output logic                          busy,
  output logic [uplink_pkg::ADDR_W:0]   pixels_sent,
  output logic                          txd
);
  import uplink_pkg::*;

  // address width of the actual frame
  localparam int AW = $clog2(NUM_PIXELS);

  // control
  logic send_active;
  logic wr_allowed;
  logic frame_done;
  logic reader_empty;
  logic tx_idle;

  // frame read path
  logic          wr_en;
  logic          pix_req;
  logic          rd_en;
  logic [AW-1:0] rd_addr;
  pixel_t        rd_data;
  logic          rd_data_valid;

  // byte path
  logic       byte_valid;
  logic       byte_ready;
  logic [7:0] byte_data;

  //////////////////////
  // load side
  //////////////////////

  assign pix_wr_ready = wr_allowed;
  // write lands only on an accepted beat
  assign wr_en = wr_allowed & pix_wr_valid;

  //////////////////////
  // control
  //////////////////////

  uplink_fsm u_fsm (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .send_start   (send_start),
    .frame_done   (frame_done),
    .reader_empty (reader_empty),
    .tx_idle      (tx_idle),
    .send_active  (send_active),
    .wr_allowed   (wr_allowed),
    .busy         (busy)
  );

  pixel_counter #(.NUM_PIXELS(NUM_PIXELS)) u_counter (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .send_active (send_active),
    .pix_req     (pix_req),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .frame_done  (frame_done),
    .pixels_sent (pixels_sent)
  );

  //////////////////////
  // data path
  //////////////////////

  frame_store #(.NUM_PIXELS(NUM_PIXELS)) u_store (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .wr_en         (wr_en),
    .wr_addr       (pix_wr_addr[AW-1:0]),
    .wr_data       (pix_wr_data),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  // pixel to green, blue, red bytes
  frame_reader u_reader (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .byte_ready    (byte_ready),
    .pix_req       (pix_req),
    .byte_valid    (byte_valid),
    .byte_data     (byte_data),
    .reader_empty  (reader_empty)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk        (clk),
    .uart_reset (uart_reset),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .tx_idle    (tx_idle),
    .txd        (txd)
  );

endmodule

// ==== uplink_asserts.sv ====
`timescale 1ns/1ps

module uplink_asserts (
  input logic       clk,
  input logic       uart_reset,
  input logic       txd,
  input logic       busy,
  input logic       pix_wr_ready,
  input logic       byte_valid,
  input logic       byte_ready,
  input logic [7:0] byte_data,
  input logic       rd_en,
  input logic       rd_data_valid
);

  // failures seen so far, read by the testbench at the end
  int fail_count = 0;

  //////////////////////
  // line and load side
  //////////////////////

  // serial line rests high between sends
  line_idle_high: assert property (@(posedge clk) disable iff (uart_reset)
    !busy |-> txd)
    else begin
      $error("txd low while the uplink is idle");
      fail_count++;
    end

  // frame closed to writes during a send
  no_write_when_busy: assert property (@(posedge clk) disable iff (uart_reset)
    busy |-> !pix_wr_ready)
    else begin
      $error("pix_wr_ready high while busy");
      fail_count++;
    end

  //////////////////////
  // internal handshakes
  //////////////////////

  // held byte must not move until the serializer takes it
  byte_held_stable: assert property (@(posedge clk) disable iff (uart_reset)
    byte_valid && !byte_ready |=> byte_valid && $stable(byte_data))
    else begin
      $error("byte_valid or byte_data changed before acceptance");
      fail_count++;
    end

  // one cycle read latency
  read_latency_one: assert property (@(posedge clk) disable iff (uart_reset)
    rd_data_valid == $past(rd_en))
    else begin
      $error("rd_data_valid does not follow rd_en by one cycle");
      fail_count++;
    end

endmodule

bind frame_uplink uplink_asserts u_asserts (
  .clk           (clk),
  .uart_reset    (uart_reset),
  .txd           (txd),
  .busy          (busy),
  .pix_wr_ready  (pix_wr_ready),
  .byte_valid    (byte_valid),
  .byte_ready    (byte_ready),
  .byte_data     (byte_data),
  .rd_en         (rd_en),
  .rd_data_valid (rd_data_valid)
);

// ==== tb_frame_uplink.sv ====
`timescale 1ns/1ps

module tb_frame_uplink;
  import uplink_pkg::*;

  localparam int NUM_PIX = 16;
  localparam int CLKS = 8;
  localparam int CLK_NS = 8;
  localparam int BIT_NS = CLKS * CLK_NS;
  localparam int FRAME_BYTES = 3 * NUM_PIX;
  // two character times of quiet line after busy drops
  localparam int QUIET_CYCLES = 2 * 10 * CLKS;
  localparam int LOAD_CYCLES = 2 * NUM_PIX * 4 + 10;
  localparam int TIMEOUT_CYCLES = 2 * FRAME_BYTES * 10 * CLKS * 2 + LOAD_CYCLES;

  logic              clk;
  logic              uart_reset;
  logic              pix_wr_valid;
  logic [ADDR_W-1:0] pix_wr_addr;
  pixel_t            pix_wr_data;
  logic              send_start;
  logic              pix_wr_ready;
  logic              busy;
  logic [ADDR_W:0]   pixels_sent;
  logic              txd;

  // reference frame and the byte stream it should produce
  logic [7:0]  model [NUM_PIX];
  logic [7:0]  expected_q [$];
  logic [15:0] lfsr;
  int          errors = 0;
  int          pass_tests = 0;
  int          fail_tests = 0;
  int          cycles = 0;
  int          start_bits = 0;

  frame_uplink #(.NUM_PIXELS(NUM_PIX), .CLKS_PER_BIT(CLKS)) UUT (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .pix_wr_valid (pix_wr_valid),
    .pix_wr_addr  (pix_wr_addr),
    .pix_wr_data  (pix_wr_data),
    .send_start   (send_start),
    .pix_wr_ready (pix_wr_ready),
    .busy         (busy),
    .pixels_sent  (pixels_sent),
    .txd          (txd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // runaway guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the uplink never finished", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // one count per start bit
  // data bit edges are skipped up to the middle of the stop bit
  initial begin
    forever begin
      @(negedge txd);
      if (!uart_reset) begin
        start_bits++;
        #(10 * BIT_NS - BIT_NS / 2);
      end
    end
  end

  //////////////////////
  // checks and random bits
  //////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // galois lfsr over x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) lfsr_step = (s >> 1) ^ 16'hB400;
    else lfsr_step = s >> 1;
  endfunction

  // one step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic close_test(input string name, input int errors_at_start);
    if (errors == errors_at_start) begin
      pass_tests++;
      $display("test %s: passed", name);
    end else begin
      fail_tests++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  //////////////////////
  // stimulus
  //////////////////////

  // entered and left at 1 ns past a rising edge
  task automatic write_pixel(input int addr, input logic [7:0] data, output logic taken);
    pix_wr_valid = 1'b1;
    pix_wr_addr = ADDR_W'(addr);
    pix_wr_data = data;
    taken = pix_wr_ready;
    @(posedge clk);
    #1;
    pix_wr_valid = 1'b0;
    if (taken) model[addr] = data;
  endtask

  // random pixel after a random gap
  // the idle frame must take it
  task automatic load_pixel(input int addr);
    logic [15:0] gap;
    logic [15:0] d;
    logic        taken;
    take_bits(2, gap);
    take_bits(8, d);
    repeat (gap[1:0]) begin
      @(posedge clk);
      #1;
    end
    write_pixel(addr, d[7:0], taken);
    check_value("pix_wr_ready", 1, taken);
  endtask

  task automatic pulse_start();
    send_start = 1'b1;
    @(posedge clk);
    #1;
    send_start = 1'b0;
  endtask

  // writes and a stray start while the frame is going out
  task automatic try_writes_while_busy();
    logic [15:0] a;
    logic [15:0] d;
    logic        taken;
    for (int i = 0; i < 4; i++) begin
      take_bits(4, a);
      take_bits(8, d);
      write_pixel(a[3:0], d[7:0], taken);
      check_value("pix_wr_ready", 0, taken);
    end
    pulse_start();
  endtask

  //////////////////////
  // serial side
  //////////////////////

  // green then blue then red per pixel
  // each field in the top bits
  task automatic build_expected();
    expected_q.delete();
    for (int a = 0; a < NUM_PIX; a++) begin
      expected_q.push_back({model[a][4:2], 5'b0});
      expected_q.push_back({model[a][1:0], 6'b0});
      expected_q.push_back({model[a][7:5], 5'b0});
    end
  endtask

  // samples at mid-bit away from the line's edges
  task automatic decode_byte(output logic [7:0] data, output time stop_t);
    @(negedge txd);
    #(BIT_NS / 2);
    check_true(txd == 1'b0, "start bit not low at mid-bit");
    for (int i = 0; i < 8; i++) begin
      #(BIT_NS);
      data[i] = txd;
    end
    #(BIT_NS);
    check_true(txd == 1'b1, "stop bit not high at mid-bit");
    stop_t = $time;
  endtask

  task automatic decode_frame(output time stop_t);
    logic [7:0] got;
    for (int i = 0; i < FRAME_BYTES; i++) begin
      decode_byte(got, stop_t);
      check_value($sformatf("txd byte %0d", i), expected_q[i], got);
    end
  endtask

  task automatic run_send(input bit poke, output time fall_t, output time stop_t);
    int starts_before;
    starts_before = start_bits;
    build_expected();
    fork
      decode_frame(stop_t);
      begin
        pulse_start();
        check_value("busy", 1, busy);
        if (poke) try_writes_while_busy();
        wait (busy == 1'b0);
        fall_t = $time;
      end
    join
    // nothing more may leave the line
    repeat (QUIET_CYCLES) @(posedge clk);
    #1;
    check_value("txd byte count", FRAME_BYTES, start_bits - starts_before);
  endtask

  //////////////////////
  // test sequence
  //////////////////////

  initial begin
    int   start_errors;
    time  fall_t;
    time  stop_t;
    logic [15:0] a;
    lfsr = 16'd8;
    uart_reset = 1'b1;
    pix_wr_valid = 1'b0;
    pix_wr_addr = '0;
    pix_wr_data = '0;
    send_start = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    uart_reset = 1'b0;

    start_errors = errors;
    check_value("txd", 1, txd);
    check_value("busy", 0, busy);
    check_value("pix_wr_ready", 1, pix_wr_ready);
    check_value("pixels_sent", 0, pixels_sent);
    close_test("reset", start_errors);

    start_errors = errors;
    for (int i = 0; i < NUM_PIX; i++) load_pixel(i);
    close_test("load", start_errors);

    start_errors = errors;
    run_send(1'b0, fall_t, stop_t);
    close_test("send", start_errors);

    start_errors = errors;
    check_true(fall_t > stop_t, "busy fell before the last stop bit");
    check_value("pixels_sent", NUM_PIX, pixels_sent);
    check_value("busy", 0, busy);
    close_test("completion", start_errors);

    // rewrite some pixels and send twice
    // writes are poked into the first of the two sends
    start_errors = errors;
    for (int i = 0; i < 6; i++) begin
      take_bits(4, a);
      load_pixel(a[3:0]);
    end
    run_send(1'b1, fall_t, stop_t);
    run_send(1'b0, fall_t, stop_t);
    check_value("pixels_sent", NUM_PIX, pixels_sent);
    close_test("writes during send", start_errors);

    start_errors = errors;
    check_value("bound assertion failures", 0, UUT.u_asserts.fail_count);
    close_test("bound assertions", start_errors);

    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
uplink_pkg.sv
frame_store.sv
pixel_counter.sv
frame_reader.sv
uart_tx.sv
uplink_fsm.sv
frame_uplink.sv
uplink_asserts.sv
tb_frame_uplink.sv
